// File: verilog/csr_map_pkg.sv
// CSR map package with address and access-function encodings and the write port
package csr_map_pkg;

    // Implemented CSR addresses, bits 9:8 give the lowest level allowed
    typedef enum logic [11:0] {
        CSR_SSTATUS   = 12'h100,     // Shares mstatus
        CSR_SIE       = 12'h104,     // Shares mie
        CSR_STVEC     = 12'h105,
        CSR_SSCRATCH  = 12'h140,
        CSR_SEPC      = 12'h141,
        CSR_SCAUSE    = 12'h142,
        CSR_STVAL     = 12'h143,
        CSR_SIP       = 12'h144,     // Shares mip
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MEDELEG   = 12'h302,
        CSR_MIDELEG   = 12'h303,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hb00,
        CSR_MINSTRET  = 12'hb02,
        CSR_CYCLE     = 12'hc00,     // User shadow of mcycle
        CSR_INSTRET   = 12'hc02,     // User shadow of minstret
        CSR_MVENDORID = 12'hf11,
        CSR_MARCHID   = 12'hf12,
        CSR_MIMPID    = 12'hf13,
        CSR_MHARTID   = 12'hf14
    } csr_addr_e;

    // Low two bits of funct3
    typedef enum logic [1:0] {
        FUNC_READ  = 2'b00,          // Read only, no write
        FUNC_WRITE = 2'b01,          // CSRRW
        FUNC_SET   = 2'b10,          // CSRRS
        FUNC_CLEAR = 2'b11           // CSRRC
    } csr_func_e;

    // One committed CSR write
    typedef struct packed {
        logic        valid;
        csr_addr_e   addr;
        logic [63:0] data;           // Final value after set or clear
    } csr_wr_t;

endpackage

// File: verilog/priv_pkg.sv
// Privilege package with levels, mstatus fields and trap, return and interrupt records
package priv_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3                // Level 2 is reserved
    } priv_e;

    // mstatus bit positions
    localparam int ST_SIE  = 1;
    localparam int ST_MIE  = 3;
    localparam int ST_SPIE = 5;
    localparam int ST_MPIE = 7;
    localparam int ST_SPP  = 8;
    localparam int ST_MPP  = 11;     // Low bit of the 12:11 field
    localparam int ST_UXL  = 32;     // Low bit of 33:32
    localparam int ST_SXL  = 34;     // Low bit of 35:34

    localparam logic [1:0] XL_64 = 2'd2;   // 64-bit XLEN for S and U

    typedef struct packed {
        logic        valid;
        logic [63:0] epc;
        logic [63:0] tval;
        logic [63:0] cause;          // Bit 63 marks an interrupt
    } trap_t;

    typedef struct packed {
        logic  valid;
        priv_e level;                // M for MRET, S for SRET
    } ret_t;

    typedef struct packed {
        logic       valid;
        logic [5:0] code;            // Interrupt number
    } irq_t;

    // Trap register file as seen by readers
    typedef struct packed {
        logic [63:0] mstatus;
        logic [63:0] medeleg;
        logic [63:0] mideleg;
        logic [63:0] mtvec;
        logic [63:0] stvec;
        logic [63:0] mepc;
        logic [63:0] sepc;
        logic [63:0] mcause;
        logic [63:0] scause;
        logic [63:0] mtval;
        logic [63:0] stval;
        logic [63:0] mscratch;
        logic [63:0] sscratch;
    } trap_regs_t;

endpackage

// File: verilog/csr_access.sv
// CSR access decoder: read mux, set and clear result, access exceptions and write port
`timescale 1ns/100ps

module csr_access #(
    parameter logic [63:0] HART_ID = 64'd0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rqst,      // Single-cycle access strobe
    input  csr_map_pkg::csr_func_e func,
    input  logic            [11:0] addr,
    input  logic            [63:0] wdat,
    input  priv_pkg::priv_e        level,     // Current privilege
    input  priv_pkg::trap_regs_t   regs,
    input  logic            [63:0] mcycle,
    input  logic            [63:0] minstret,
    input  logic            [63:0] mip,
    input  logic            [63:0] mie,
    output logic            [63:0] rdat,
    output logic                   eout,      // Access exception
    output logic                   flush,
    output csr_map_pkg::csr_wr_t   wr
);
    import csr_map_pkg::*;

    // RV64 with A, C, I, M, S and U
    localparam logic [63:0] MISA = {2'd2, 36'd0, 26'h141105};

    logic        unimpl;                      // No CSR at addr
    logic        user_ctr;                    // cycle or instret
    logic [63:0] wres;                        // Value the access would write

    always_comb begin
        unimpl = 1'b0;
        case (addr)
            CSR_MSTATUS, CSR_SSTATUS: rdat = regs.mstatus;
            CSR_MISA:                 rdat = MISA;
            CSR_MEDELEG:              rdat = regs.medeleg;
            CSR_MIDELEG:              rdat = regs.mideleg;
            CSR_MIE, CSR_SIE:         rdat = mie;
            CSR_MIP, CSR_SIP:         rdat = mip;
            CSR_MTVEC:                rdat = regs.mtvec;
            CSR_STVEC:                rdat = regs.stvec;
            CSR_MSCRATCH:             rdat = regs.mscratch;
            CSR_SSCRATCH:             rdat = regs.sscratch;
            CSR_MEPC:                 rdat = regs.mepc;
            CSR_SEPC:                 rdat = regs.sepc;
            CSR_MCAUSE:               rdat = regs.mcause;
            CSR_SCAUSE:               rdat = regs.scause;
            CSR_MTVAL:                rdat = regs.mtval;
            CSR_STVAL:                rdat = regs.stval;
            CSR_MCYCLE, CSR_CYCLE:    rdat = mcycle;
            CSR_MINSTRET, CSR_INSTRET: rdat = minstret;
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID: rdat = 64'd0;  // Not reported
            CSR_MHARTID:              rdat = HART_ID;
            default: begin
                rdat   = 64'd0;
                unimpl = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (func)
            FUNC_WRITE: wres = wdat;
            FUNC_SET:   wres = rdat | wdat;
            FUNC_CLEAR: wres = rdat & ~wdat;
            default:    wres = rdat;          // Read leaves value as is
        endcase
    end

    always_comb user_ctr = addr == CSR_CYCLE || addr == CSR_INSTRET;

    always_comb eout = rqst & (unimpl |
                               (addr[9:8] > level) |            // Privilege too low
                               (user_ctr & (wres != rdat)));    // User counters are read only

    always_comb begin
        wr.valid = rqst & ~eout;
        wr.addr  = csr_addr_e'(addr);
        wr.data  = wres;
    end

    // Status and vector changes redirect the pipeline
    always_comb flush = wr.valid &
                        (addr inside {CSR_MSTATUS, CSR_SSTATUS, CSR_MTVEC, CSR_STVEC});

endmodule

// File: verilog/csr_trap.sv
// Trap state holder: privilege level, mstatus, delegation, vectors and trap records
`timescale 1ns/100ps

module csr_trap (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_map_pkg::csr_wr_t wr,
    input  priv_pkg::trap_t      trap,
    input  priv_pkg::ret_t       ret,
    output priv_pkg::priv_e      level,
    output logic                 deleg,       // Pending trap goes to S
    output priv_pkg::trap_regs_t regs
);
    import csr_map_pkg::*;
    import priv_pkg::*;

    localparam logic [63:0] STATUS_WMASK = (64'd1 << ST_SIE) | (64'd1 << ST_MIE) |
                                           (64'd1 << ST_SPIE) | (64'd1 << ST_MPIE) |
                                           (64'd1 << ST_SPP) | (64'd3 << ST_MPP);
    localparam logic [63:0] STATUS_FIXED = (64'(XL_64) << ST_SXL) | (64'(XL_64) << ST_UXL);
    localparam logic [63:0] STATUS_RESET = STATUS_FIXED | (64'(PRIV_M) << ST_MPP);

    logic [63:0] status_wr;                   // Legal mstatus write value
    logic        xfer;                        // Trap or return this cycle

    // Only M can delegate, and only traps taken from below M
    always_comb begin
        if (trap.cause[63])
            deleg = (level != PRIV_M) & regs.mideleg[trap.cause[5:0]];
        else
            deleg = (level != PRIV_M) & regs.medeleg[trap.cause[5:0]];
    end

    always_comb status_wr = (wr.data & STATUS_WMASK) | STATUS_FIXED;   // SD stays zero
    always_comb xfer = trap.valid | (ret.valid & (ret.level != PRIV_U));

    always_ff @(posedge clk) begin
        if (rst) begin
            level         <= PRIV_M;
            regs          <= '0;
            regs.mstatus  <= STATUS_RESET;
        end else begin
            // CSR writes first so that traps and returns override them
            if (wr.valid) begin
                case (wr.addr)
                    CSR_MSTATUS, CSR_SSTATUS: if (!xfer) regs.mstatus <= status_wr;
                    CSR_MEDELEG:  regs.medeleg  <= wr.data & ~(64'd1 << 11);  // No M ecall
                    CSR_MIDELEG:  regs.mideleg  <= wr.data;
                    CSR_MTVEC:    regs.mtvec    <= wr.data & ~64'd3;        // Direct mode only
                    CSR_STVEC:    regs.stvec    <= wr.data & ~64'd3;
                    CSR_MSCRATCH: regs.mscratch <= wr.data;
                    CSR_SSCRATCH: regs.sscratch <= wr.data;
                    CSR_MEPC:     regs.mepc     <= wr.data;
                    CSR_SEPC:     regs.sepc     <= wr.data;
                    CSR_MCAUSE:   regs.mcause   <= wr.data;
                    CSR_SCAUSE:   regs.scause   <= wr.data;
                    CSR_MTVAL:    regs.mtval    <= wr.data;
                    CSR_STVAL:    regs.stval    <= wr.data;
                    default: ;                // Held elsewhere
                endcase
            end
            if (trap.valid) begin
                if (deleg) begin
                    level                  <= PRIV_S;
                    regs.sepc              <= trap.epc;
                    regs.stval             <= trap.tval;
                    regs.scause            <= trap.cause;
                    regs.mstatus[ST_SPP]   <= level[0];                  // Came from S or U
                    regs.mstatus[ST_SPIE]  <= regs.mstatus[ST_SIE];
                    regs.mstatus[ST_SIE]   <= 1'b0;
                end else begin
                    level                  <= PRIV_M;
                    regs.mepc              <= trap.epc;
                    regs.mtval             <= trap.tval;
                    regs.mcause            <= trap.cause;
                    regs.mstatus[ST_MPP +: 2] <= level;
                    regs.mstatus[ST_MPIE]  <= regs.mstatus[ST_MIE];
                    regs.mstatus[ST_MIE]   <= 1'b0;
                end
            end else if (ret.valid) begin
                if (ret.level == PRIV_M) begin                           // MRET
                    level                  <= priv_e'(regs.mstatus[ST_MPP +: 2]);
                    regs.mstatus[ST_MPP +: 2] <= PRIV_U;
                    regs.mstatus[ST_MIE]   <= regs.mstatus[ST_MPIE];
                    regs.mstatus[ST_MPIE]  <= 1'b1;
                end else if (ret.level == PRIV_S) begin                  // SRET
                    level                  <= priv_e'({1'b0, regs.mstatus[ST_SPP]});
                    regs.mstatus[ST_SPP]   <= 1'b0;
                    regs.mstatus[ST_SIE]   <= regs.mstatus[ST_SPIE];
                    regs.mstatus[ST_SPIE]  <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/csr_counters.sv
// Machine cycle and retired-instruction counters with CSR write override
`timescale 1ns/100ps

module csr_counters (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_map_pkg::csr_wr_t wr,
    input  logic                 retire,      // One instruction retired
    output logic          [63:0] mcycle,
    output logic          [63:0] minstret
);
    import csr_map_pkg::*;

    always_ff @(posedge clk) begin
        if (rst)
            mcycle <= 64'd0;
        else if (wr.valid && wr.addr == CSR_MCYCLE)
            mcycle <= wr.data;                // Write skips the increment
        else
            mcycle <= mcycle + 64'd1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            minstret <= 64'd0;
        else if (wr.valid && wr.addr == CSR_MINSTRET)
            minstret <= wr.data;
        else if (retire)
            minstret <= minstret + 64'd1;
    end

endmodule

// File: verilog/csr_interrupts.sv
// Interrupt pending and enable registers with local and global interrupt selection
`timescale 1ns/100ps

module csr_interrupts (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_map_pkg::csr_wr_t wr,
    input  logic          [63:0] ext_ip,      // Lines from the platform
    input  priv_pkg::priv_e      level,
    input  logic                 mstatus_mie,
    input  logic                 mstatus_sie,
    input  logic          [63:0] mideleg,
    output logic          [63:0] mip,
    output logic          [63:0] mie,
    output logic                 intl,        // Any local pending and enabled
    output priv_pkg::irq_t       irq          // Interrupt to take now
);
    import csr_map_pkg::*;
    import priv_pkg::*;

    logic [63:0] mip_base;                    // Software-writable pending bits

    always_ff @(posedge clk) begin
        if (rst) begin
            mip_base <= 64'd0;
            mie      <= 64'd0;
        end else if (wr.valid) begin
            if (wr.addr == CSR_MIP || wr.addr == CSR_SIP) mip_base <= wr.data;
            if (wr.addr == CSR_MIE || wr.addr == CSR_SIE) mie      <= wr.data;
        end
    end

    // MEIP, SEIP, MTIP and STIP come from outside
    always_comb mip = (ext_ip & 64'h0aa0) | (mip_base & 64'h0113);

    // Later indices overwrite, so the highest enabled bit wins
    always_comb begin
        intl = 1'b0;
        irq  = '0;
        for (int i = 0; i < 12; i++) begin
            if (mip[i] & mie[i]) begin
                intl = 1'b1;
                if (!mideleg[i] && (level != PRIV_M || mstatus_mie) ||
                    mideleg[i] && (level == PRIV_U || level == PRIV_S && mstatus_sie)) begin
                    irq.valid = 1'b1;
                    irq.code  = 6'(i);
                end
            end
        end
    end

endmodule

// File: verilog/csr_top.sv
// CSR block top level for a 64-bit hart, joining access, trap, counter and interrupt logic
`timescale 1ns/100ps

module csr_top #(
    parameter logic [63:0] HART_ID = 64'd0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rqst,
    input  csr_map_pkg::csr_func_e func,
    input  logic            [11:0] addr,
    input  logic            [63:0] wdat,
    input  priv_pkg::trap_t        trap,      // Exception or interrupt taken
    input  priv_pkg::ret_t         ret,       // MRET or SRET
    input  logic                   retire,
    input  logic            [63:0] ext_ip,
    output logic            [63:0] rdat,
    output logic                   eout,
    output logic                   flush,
    output logic                   intl,
    output priv_pkg::irq_t         irq,
    output logic            [63:0] status,    // mstatus
    output logic            [63:0] tvec,      // Vector of the pending trap target
    output logic            [63:0] mepc,
    output logic            [63:0] sepc
);
    import csr_map_pkg::*;
    import priv_pkg::*;

    csr_wr_t     wr;                          // Committed write to all holders
    trap_regs_t  regs;
    priv_e       level;
    logic        deleg;
    logic [63:0] mcycle, minstret, mip, mie;

    csr_access #(.HART_ID(HART_ID)) csr_access_i (
        .clk(clk), .rst(rst), .rqst(rqst), .func(func), .addr(addr), .wdat(wdat),
        .level(level), .regs(regs), .mcycle(mcycle), .minstret(minstret),
        .mip(mip), .mie(mie), .rdat(rdat), .eout(eout), .flush(flush), .wr(wr)
    );

    csr_trap csr_trap_i (
        .clk(clk), .rst(rst), .wr(wr), .trap(trap), .ret(ret),
        .level(level), .deleg(deleg), .regs(regs)
    );

    csr_counters csr_counters_i (
        .clk(clk), .rst(rst), .wr(wr), .retire(retire),
        .mcycle(mcycle), .minstret(minstret)
    );

    csr_interrupts csr_interrupts_i (
        .clk(clk), .rst(rst), .wr(wr), .ext_ip(ext_ip), .level(level),
        .mstatus_mie(regs.mstatus[ST_MIE]), .mstatus_sie(regs.mstatus[ST_SIE]),
        .mideleg(regs.mideleg), .mip(mip), .mie(mie), .intl(intl), .irq(irq)
    );

    always_comb status = regs.mstatus;
    always_comb tvec   = deleg ? regs.stvec : regs.mtvec;   // Follows delegation of trap input
    always_comb mepc   = regs.mepc;
    always_comb sepc   = regs.sepc;

endmodule

// File: testbench/clock_gen.sv
// Clock and synchronous reset generator for the CSR testbench
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                          // Released on a rising edge
    end

endmodule

// File: testbench/csr_tb.sv
// CSR block testbench with LFSR data, a reference model and assertion checks
`timescale 1ns/100ps

module csr_tb;
    import csr_map_pkg::*;
    import priv_pkg::*;

    localparam int          PERIOD      = 10;
    localparam logic [63:0] WMASK       = 64'h19aa;                 // SIE MIE SPIE MPIE SPP MPP
    localparam logic [63:0] FIXED       = 64'h0000_000a_0000_0000;  // SXL and UXL at 2
    localparam int          TEST_CYCLES = 10 + 30 + 20 + 50 + 30 + 40;  // Tests 1 to 6
    localparam int          LIMIT_NS    = (TEST_CYCLES + 100) * PERIOD;

    typedef struct packed {
        priv_e       level;
        logic [63:0] mie;
        logic [63:0] sw;                      // Software-written mip bits
        logic [63:0] ext;                     // Last ext_ip driven
        trap_regs_t  r;
    } model_t;

    logic        clk, rst, rqst, retire, eout, flush, intl;
    csr_func_e   func;
    logic [11:0] addr;
    logic [63:0] wdat, ext_ip, rdat, status, tvec, mepc, sepc;
    trap_t       trap;
    ret_t        ret;
    irq_t        irq;
    model_t      m;                           // Expected state after the next edge
    logic [31:0] lfsr;
    logic [63:0] got;                         // rdat of the last access
    int          errors, mark, tests;

    clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(2)) clock_gen_i (.clk(clk), .rst(rst));

    csr_top #(.HART_ID(64'd5)) csr_top_i (
        .clk(clk), .rst(rst), .rqst(rqst), .func(func), .addr(addr), .wdat(wdat),
        .trap(trap), .ret(ret), .retire(retire), .ext_ip(ext_ip), .rdat(rdat),
        .eout(eout), .flush(flush), .intl(intl), .irq(irq), .status(status),
        .tvec(tvec), .mepc(mepc), .sepc(sepc)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    function automatic logic [63:0] apply_func(input csr_func_e f, input logic [63:0] old, d);
        case (f)
            FUNC_WRITE: return d;
            FUNC_SET:   return old | d;
            FUNC_CLEAR: return old & ~d;
            default:    return old;
        endcase
    endfunction

    // 0 unimplemented, 1 modeled, 2 implemented but value not modeled
    function automatic int model_read(input logic [11:0] a, output logic [63:0] v);
        v = '0;
        case (a)
            CSR_MSTATUS, CSR_SSTATUS: v = m.r.mstatus;
            CSR_MEDELEG:      v = m.r.medeleg;
            CSR_MIDELEG:      v = m.r.mideleg;
            CSR_MIE, CSR_SIE: v = m.mie;
            CSR_MIP, CSR_SIP: v = (m.ext & 64'h0aa0) | (m.sw & 64'h0113);
            CSR_MTVEC:        v = m.r.mtvec;
            CSR_STVEC:        v = m.r.stvec;
            CSR_MSCRATCH:     v = m.r.mscratch;
            CSR_SSCRATCH:     v = m.r.sscratch;
            CSR_MEPC:         v = m.r.mepc;
            CSR_SEPC:         v = m.r.sepc;
            CSR_MCAUSE:       v = m.r.mcause;
            CSR_SCAUSE:       v = m.r.scause;
            CSR_MTVAL:        v = m.r.mtval;
            CSR_STVAL:        v = m.r.stval;
            CSR_MHARTID:      v = 64'd5;
            CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
            CSR_MCYCLE, CSR_MINSTRET, CSR_CYCLE, CSR_INSTRET: return 2;
            default:          return 0;
        endcase
        return 1;
    endfunction

    function automatic void model_write(input logic [11:0] a, input logic [63:0] v);
        case (a)
            CSR_MSTATUS, CSR_SSTATUS: m.r.mstatus = (v & WMASK) | FIXED;
            CSR_MEDELEG:      m.r.medeleg  = v & ~64'h800;   // Bit 11 reads zero
            CSR_MIDELEG:      m.r.mideleg  = v;
            CSR_MIE, CSR_SIE: m.mie        = v;
            CSR_MIP, CSR_SIP: m.sw         = v;
            CSR_MTVEC:        m.r.mtvec    = v & ~64'd3;
            CSR_STVEC:        m.r.stvec    = v & ~64'd3;
            CSR_MSCRATCH:     m.r.mscratch = v;
            CSR_SSCRATCH:     m.r.sscratch = v;
            default: ;
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] got_v, exp_v);
        assert (got_v === exp_v) else begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got_v, exp_v);
            errors++;
        end
    endtask

    // One access cycle, sampled at the falling edge
    task automatic access(input csr_func_e f, input logic [11:0] a, input logic [63:0] d,
                          input logic ctr_fault);
        logic [63:0] exp_v;
        int          kind;
        logic        fault;
        kind  = model_read(a, exp_v);
        fault = kind == 0 || a[9:8] > m.level || ctr_fault;
        @(posedge clk);
        rqst   <= 1'b1;
        retire <= 1'b0;
        func   <= f;
        addr   <= a;
        wdat   <= d;
        @(negedge clk);
        got = rdat;
        check("eout", eout, fault);
        check("flush", flush,
              !fault && a inside {CSR_MSTATUS, CSR_SSTATUS, CSR_MTVEC, CSR_STVEC});
        if (kind == 1 && !fault) begin
            check($sformatf("rdat[%h]", a), rdat, exp_v);
            model_write(a, apply_func(f, exp_v, d));   // Commits at the next edge
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            rqst   <= 1'b0;
            retire <= 1'b0;
            @(negedge clk);
            check("eout", eout, 0);
            check("flush", flush, 0);
        end
    endtask

    task automatic take_trap(input logic [63:0] cause, epc, tval);
        logic to_s;
        to_s = m.level != PRIV_M &&
               (cause[63] ? m.r.mideleg[cause[5:0]] : m.r.medeleg[cause[5:0]]);
        @(posedge clk);
        rqst <= 1'b0;
        trap <= {1'b1, epc, tval, cause};
        @(negedge clk);
        check("tvec", tvec, to_s ? m.r.stvec : m.r.mtvec);
        if (to_s) begin
            m.r.sepc       = epc;
            m.r.stval      = tval;
            m.r.scause     = cause;
            m.r.mstatus[8] = m.level[0];      // SPP
            m.r.mstatus[5] = m.r.mstatus[1];
            m.r.mstatus[1] = 1'b0;
            m.level        = PRIV_S;
        end else begin
            m.r.mepc             = epc;
            m.r.mtval            = tval;
            m.r.mcause           = cause;
            m.r.mstatus[12:11]   = m.level;   // MPP
            m.r.mstatus[7]       = m.r.mstatus[3];
            m.r.mstatus[3]       = 1'b0;
            m.level              = PRIV_M;
        end
        @(posedge clk);
        trap.valid <= 1'b0;
    endtask

    task automatic do_return(input priv_e lv);
        @(posedge clk);
        rqst <= 1'b0;
        ret  <= {1'b1, lv};
        if (lv == PRIV_M) begin
            m.level            = priv_e'(m.r.mstatus[12:11]);
            m.r.mstatus[12:11] = 2'd0;
            m.r.mstatus[3]     = m.r.mstatus[7];
            m.r.mstatus[7]     = 1'b1;
        end else begin
            m.level        = priv_e'({1'b0, m.r.mstatus[8]});
            m.r.mstatus[8] = 1'b0;
            m.r.mstatus[1] = m.r.mstatus[5];
            m.r.mstatus[5] = 1'b1;
        end
        @(posedge clk);
        ret.valid <= 1'b0;
    endtask

    // Outputs, then the level seen through an M and an S probe
    task automatic check_state;
        idle(1);
        check("status", status, m.r.mstatus);
        check("mepc", mepc, m.r.mepc);
        check("sepc", sepc, m.r.sepc);
        access(FUNC_READ, CSR_MSCRATCH, 0, 0);
        access(FUNC_READ, CSR_SSCRATCH, 0, 0);
    endtask

    task automatic check_irq(input logic [63:0] ext);
        logic [63:0] pend;
        irq_t        exp_irq;
        logic        on;
        int          i;
        m.ext   = ext;
        pend    = ((ext & 64'h0aa0) | (m.sw & 64'h0113)) & m.mie;
        exp_irq = '0;
        for (i = 0; i < 12; i++) begin
            on = m.r.mideleg[i] ? (m.level == PRIV_U || m.level == PRIV_S && m.r.mstatus[1])
                                : (m.level != PRIV_M || m.r.mstatus[3]);
            if (pend[i] && on)
                exp_irq = {1'b1, 6'(i)};      // Highest wins
        end
        @(posedge clk);
        rqst   <= 1'b0;
        ext_ip <= ext;
        @(negedge clk);
        check("intl", intl, |pend[11:0]);
        check("irq", irq, exp_irq);
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 errors == mark ? "ok" : "failed", errors - mark);
        mark = errors;
    endtask

    initial begin
        #(LIMIT_NS);
        $display("Watchdog expired after %0d ns with tests still running", LIMIT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [63:0] v, w;
        int          i, n;
        errors = 0;
        mark   = 0;
        tests  = 0;
        lfsr   = 32'h9727;
        m      = '0;
        m.level     = PRIV_M;
        m.r.mstatus = FIXED | 64'h1800;       // MPP at M
        rqst   <= 1'b0;
        func   <= FUNC_READ;
        addr   <= '0;
        wdat   <= '0;
        trap   <= '0;
        ret    <= '0;
        retire <= 1'b0;
        ext_ip <= '0;

        @(negedge rst);
        idle(1);
        check("intl", intl, 0);
        check("irq.valid", irq.valid, 0);
        check("status", status, m.r.mstatus);
        access(FUNC_READ, CSR_MHARTID, 0, 0);
        access(FUNC_READ, CSR_MTVEC, 0, 0);
        access(FUNC_READ, CSR_MSCRATCH, 0, 0);
        access(FUNC_READ, CSR_MEPC, 0, 0);
        access(FUNC_READ, CSR_MSTATUS, 0, 0);
        test_done("reset values");

        for (i = 0; i < 16; i++) begin
            rand_bits(2, v);                  // Access function
            rand_bits(64, w);
            access(csr_func_e'(v[1:0]), i[0] ? CSR_SSCRATCH : CSR_MSCRATCH, w, 0);
        end
        access(FUNC_READ, CSR_MSCRATCH, 0, 0);
        access(FUNC_READ, CSR_SSCRATCH, 0, 0);
        rand_bits(64, w);
        access(FUNC_WRITE, CSR_MTVEC, w, 0);
        idle(1);
        rand_bits(64, w);
        access(FUNC_WRITE, CSR_STVEC, w, 0);
        access(FUNC_READ, CSR_MTVEC, 0, 0);
        access(FUNC_READ, CSR_STVEC, 0, 0);
        idle(1);
        test_done("write set clear");

        access(FUNC_READ, 12'h3a0, 0, 0);     // pmpcfg0 is not kept
        access(FUNC_READ, CSR_CYCLE, 0, 0);
        v = got;
        access(FUNC_WRITE, CSR_CYCLE, ~64'd0, 1);
        access(FUNC_READ, CSR_MCYCLE, 0, 0);
        check("mcycle", got, v + 64'd2);      // Still counting, not loaded
        access(FUNC_CLEAR, CSR_MSTATUS, 64'h1800, 0);
        do_return(PRIV_M);                    // Down to U
        check_state;
        access(FUNC_READ, CSR_MTVEC, 0, 0);
        access(FUNC_READ, CSR_CYCLE, 0, 0);
        test_done("access exceptions");

        rand_bits(64, v);
        rand_bits(64, w);
        take_trap(64'd2, v, w);               // Illegal instruction, kept in M
        check_state;
        access(FUNC_READ, CSR_MCAUSE, 0, 0);
        access(FUNC_READ, CSR_MTVAL, 0, 0);
        access(FUNC_SET, CSR_MEDELEG, 64'h804, 0);
        access(FUNC_READ, CSR_MEDELEG, 0, 0);
        rand_bits(64, w);
        access(FUNC_WRITE, CSR_STVEC, w, 0);
        access(FUNC_WRITE, CSR_MSTATUS, 64'h80a, 0);   // MPP S, SIE, MIE
        do_return(PRIV_M);
        check_state;
        rand_bits(64, v);
        rand_bits(64, w);
        take_trap(64'd2, v, w);               // Now delegated to S
        check_state;
        access(FUNC_READ, CSR_SCAUSE, 0, 0);
        access(FUNC_READ, CSR_STVAL, 0, 0);
        do_return(PRIV_S);
        check_state;
        take_trap(64'd3, v, w);               // Breakpoint, not delegated
        do_return(PRIV_M);
        check_state;
        take_trap(64'd3, w, v);
        check_state;
        test_done("traps and returns");

        access(FUNC_WRITE, CSR_MIE, 64'h0aaa, 0);
        check_irq(64'h800);                   // MIE clear in M
        access(FUNC_SET, CSR_MSTATUS, 64'h8, 0);
        check_irq(64'h800);
        access(FUNC_WRITE, CSR_MIP, 64'h2, 0);
        check_irq(64'h0);
        access(FUNC_WRITE, CSR_MIDELEG, 64'h2, 0);
        check_irq(64'h0);                     // Delegated bit held off in M
        access(FUNC_CLEAR, CSR_MSTATUS, 64'h1800, 0);
        do_return(PRIV_M);
        check_irq(64'h0);
        check_irq(64'h20);                    // STIP arrives from the platform
        take_trap({1'b1, 63'd9}, 64'h0, 64'h0);
        check_state;
        test_done("interrupts");

        rand_bits(64, v);
        access(FUNC_WRITE, CSR_MCYCLE, v, 0);
        access(FUNC_READ, CSR_MCYCLE, 0, 0);
        check("mcycle", got, v);
        rand_bits(3, w);
        n = 1 + int'(w[2:0]);
        idle(n);
        access(FUNC_READ, CSR_MCYCLE, 0, 0);
        check("mcycle", got, v + 64'(n));
        access(FUNC_READ, CSR_MINSTRET, 0, 0);
        v = got;
        n = 0;
        for (i = 0; i < 20; i++) begin
            rand_bits(1, w);
            @(posedge clk);
            rqst   <= 1'b0;
            retire <= w[0];
            n += int'(w[0]);
        end
        access(FUNC_READ, CSR_MINSTRET, 0, 0);
        check("minstret", got, v + 64'(n));
        idle(1);
        test_done("counters");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: sources.f
verilog/csr_map_pkg.sv
verilog/priv_pkg.sv
verilog/csr_access.sv
verilog/csr_trap.sv
verilog/csr_counters.sv
verilog/csr_interrupts.sv
verilog/csr_top.sv
testbench/clock_gen.sv
testbench/csr_tb.sv
